//--- hw/pufPkg.sv
package pufPkg;

	////////////////////
	// Bus widths and fixed sizes
	////////////////////

	localparam int INMEM_ADDRESS_WIDTH = 17;	// Input memory byte address
	localparam int OUTMEM_ADDRESS_WIDTH = 13;	// Output memory byte address
	localparam int CONFIG_BYTES = 16;			// Delay-line configuration length
	localparam int PARAM_WORDS = 2;				// Mode word, then host challenge

	////////////////////
	// Session types
	////////////////////

	// Mode word 0 -> calibration, 1 -> temperature, anything else -> test
	typedef enum logic [1:0] {
		modeCalibrate,
		modeTemperature,
		modeTest
	} pufMode_t;

	typedef struct packed {
		pufMode_t mode;				// Decoded operating mode
		logic [31:0] challenge;		// Host challenge, straight to the evaluator
	} sessionParams_t;

	// Byte k sits in bits 8k+7 .. 8k
	typedef logic [CONFIG_BYTES-1:0][7:0] pdlConfig_t;

	typedef logic [15:0] rawResponse_t;

	////////////////////
	// Host bus requests
	////////////////////

	typedef struct packed {
		logic req;
		logic [OUTMEM_ADDRESS_WIDTH-1:0] addr;
		logic [7:0] data;
	} memWrite_t;

	typedef struct packed {
		logic req;
		logic [INMEM_ADDRESS_WIDTH-1:0] addr;
	} memRead_t;

	// Evaluator controls
	typedef struct packed {
		logic calibrate;	// Level, calibration session
		logic readTemp;		// Level, temperature session
		logic trigger;		// One-cycle calibration trigger
		logic testStart;	// Held until the evaluator reports done
	} evalCtrl_t;

endpackage

//--- hw/sessionControl.sv
`timescale 1ns/10ps

module sessionControl (
	input logic clk,
	input logic reset,
	input logic userRunValue,
	output logic userRunClear,
	output logic paramStart,
	output logic loadStart,
	output logic evalStart,
	output logic writeStart,
	input logic paramDone,
	input logic loadDone,
	input logic evalDone,
	input logic writeDone
);

	typedef enum logic [2:0] {
		phaseIdle,
		phaseParam,		// Register file reads
		phaseLoad,		// Configuration bytes
		phaseEval,		// One PUF evaluation
		phaseWrite		// Output memory writes
	} phase_t;

	phase_t phase;

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= phaseIdle;
			userRunClear <= 1'b0;
			paramStart <= 1'b0;
			loadStart <= 1'b0;
			evalStart <= 1'b0;
			writeStart <= 1'b0;
		end else begin
			// Strobes last one cycle
			userRunClear <= 1'b0;
			paramStart <= 1'b0;
			loadStart <= 1'b0;
			evalStart <= 1'b0;
			writeStart <= 1'b0;
			case (phase)
				phaseIdle: begin
					// Ignore the run bit while our own clear is still out
					if (userRunValue && !userRunClear) begin
						phase <= phaseParam;
						paramStart <= 1'b1;
					end
				end
				phaseParam: begin
					if (paramDone) begin
						phase <= phaseLoad;
						loadStart <= 1'b1;
					end
				end
				phaseLoad: begin
					if (loadDone) begin
						phase <= phaseEval;
						evalStart <= 1'b1;
					end
				end
				phaseEval: begin
					if (evalDone) begin
						phase <= phaseWrite;
						writeStart <= 1'b1;
					end
				end
				phaseWrite: begin
					if (writeDone) begin
						phase <= phaseIdle;
						userRunClear <= 1'b1;	// Hand the run register back
					end
				end
				default: phase <= phaseIdle;
			endcase
		end
	end

	// Phases never overlap
	assert property (@(posedge clk) disable iff (reset)
		$onehot0({paramStart, loadStart, evalStart, writeStart}));

endmodule

//--- hw/paramReader.sv
`timescale 1ns/10ps

module paramReader import pufPkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	output logic regCmdReq,
	output logic [7:0] regAddress,
	input logic regCmdAck,
	input logic regReadValid,
	input logic [31:0] regReadData,
	output sessionParams_t params,
	output logic done
);

	logic [31:0] modeWord;		// First word read
	logic [31:0] challengeWord;	// Second word read
	logic [1:0] wordCount;		// Words returned so far
	logic reading;

	always_ff @(posedge clk) begin
		if (reset) begin
			regCmdReq <= 1'b0;
			regAddress <= '0;
			wordCount <= '0;
			reading <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				regCmdReq <= 1'b1;
				regAddress <= '0;
				wordCount <= '0;
				reading <= 1'b1;
			end else if (reading) begin
				// Accepted read, move to the next register or stop asking
				if (regCmdReq && regCmdAck) begin
					if (regAddress == 8'(PARAM_WORDS - 1))
						regCmdReq <= 1'b0;
					else
						regAddress <= regAddress + 8'd1;
				end
				if (regReadValid) begin
					wordCount <= wordCount + 2'd1;
					if (wordCount == 2'(PARAM_WORDS - 1)) begin
						reading <= 1'b0;
						done <= 1'b1;	// Words settle this same edge
					end
				end
			end
		end
	end

	// Returned words shift through, mode ends up in front
	always_ff @(posedge clk) begin
		if (reading && regReadValid) begin
			modeWord <= challengeWord;
			challengeWord <= regReadData;
		end
	end

	always_comb begin
		if (modeWord == 32'd0)
			params.mode = modeCalibrate;
		else if (modeWord == 32'd1)
			params.mode = modeTemperature;
		else
			params.mode = modeTest;			// Any other word
		params.challenge = challengeWord;
	end

	// Only registers 0 and 1 are ever requested
	assert property (@(posedge clk) disable iff (reset)
		regCmdReq |-> regAddress <= 8'(PARAM_WORDS - 1));

endmodule

//--- hw/challengeLoader.sv
`timescale 1ns/10ps

module challengeLoader import pufPkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	output memRead_t rdReq,
	input logic rdAck,
	input logic rdValid,
	input logic [7:0] rdData,
	output pdlConfig_t configData,
	output logic done
);

	localparam int COUNT_WIDTH = $clog2(CONFIG_BYTES);

	logic [COUNT_WIDTH-1:0] byteCount;	// Bytes returned, also the lane index
	logic loading;
	logic outstanding;					// Accepted read, data not back yet

	always_ff @(posedge clk) begin
		if (reset) begin
			rdReq <= '0;
			byteCount <= '0;
			loading <= 1'b0;
			outstanding <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				rdReq.req <= 1'b1;
				rdReq.addr <= '0;
				byteCount <= '0;
				loading <= 1'b1;
				outstanding <= 1'b0;
			end else if (loading) begin
				if (rdReq.req && rdAck) begin
					rdReq.req <= 1'b0;
					outstanding <= 1'b1;
				end
				if (outstanding && rdValid) begin
					outstanding <= 1'b0;
					byteCount <= byteCount + 1'b1;
					if (byteCount == COUNT_WIDTH'(CONFIG_BYTES - 1)) begin
						loading <= 1'b0;
						done <= 1'b1;
					end else begin
						rdReq.req <= 1'b1;	// Next byte only after this one is back
						rdReq.addr <= rdReq.addr + 1'b1;
					end
				end
			end
		end
	end

	// Byte k into bits 8k+7 .. 8k
	always_ff @(posedge clk) begin
		if (outstanding && rdValid)
			configData[byteCount] <= rdData;
	end

	// One read in flight at most
	assert property (@(posedge clk) disable iff (reset)
		outstanding |-> !rdReq.req);

endmodule

//--- hw/evalSequencer.sv
`timescale 1ns/10ps

module evalSequencer import pufPkg::*; #(
	parameter int CALIB_WAIT_CYCLES = 10
) (
	input logic clk,
	input logic reset,
	input logic start,
	input pufMode_t mode,
	output evalCtrl_t ctrl,
	input logic testDone,
	input rawResponse_t rawIn,
	output rawResponse_t response,
	output logic done
);

	localparam int COUNT_WIDTH = $clog2(CALIB_WAIT_CYCLES + 1);

	typedef enum logic [1:0] {
		evalIdle,
		evalCalib,		// Counting after the trigger
		evalTest		// testStart held
	} evalState_t;

	evalState_t state;
	logic [COUNT_WIDTH-1:0] waitCount;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= evalIdle;
			ctrl <= '0;
			waitCount <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			ctrl.trigger <= 1'b0;	// Single cycle
			case (state)
				evalIdle: begin
					if (start) begin
						ctrl.calibrate <= (mode == modeCalibrate);
						ctrl.readTemp <= (mode == modeTemperature);
						waitCount <= '0;
						if (mode == modeCalibrate) begin
							ctrl.trigger <= 1'b1;
							state <= evalCalib;
						end else begin
							ctrl.testStart <= 1'b1;
							state <= evalTest;
						end
					end
				end
				evalCalib: begin
					waitCount <= waitCount + 1'b1;	// Zero in the trigger cycle
					if (waitCount == COUNT_WIDTH'(CALIB_WAIT_CYCLES - 1)) begin
						done <= 1'b1;
						state <= evalIdle;
					end
				end
				evalTest: begin
					if (testDone) begin
						ctrl.testStart <= 1'b0;
						done <= 1'b1;
						state <= evalIdle;
					end
				end
				default: state <= evalIdle;
			endcase
		end
	end

	// Raw response sampled as the calibration wait runs out
	always_ff @(posedge clk) begin
		if (state == evalCalib && waitCount == COUNT_WIDTH'(CALIB_WAIT_CYCLES - 1))
			response <= rawIn;
	end

endmodule

//--- hw/resultWriter.sv
`timescale 1ns/10ps

module resultWriter import pufPkg::*; #(
	parameter int RESULT_BYTES = 16,
	parameter int RESULT_READ_LATENCY = 2,
	parameter int RESULT_ADDRESS_WIDTH = 13
) (
	input logic clk,
	input logic reset,
	input logic start,
	input pufMode_t mode,
	input rawResponse_t response,
	output logic [RESULT_ADDRESS_WIDTH-1:0] resultAddr,
	input logic [7:0] resultData,
	output memWrite_t wr,
	input logic wrAck,
	output logic done
);

	localparam int LAT_WIDTH = $clog2(RESULT_READ_LATENCY + 1);

	typedef enum logic [1:0] {
		writeIdle,
		writeSettle,	// Waiting out the result memory latency
		writeBusy		// Request out, waiting for ack
	} writeState_t;

	writeState_t state;
	logic [LAT_WIDTH-1:0] latCount;
	logic calibSession;
	logic lastByte;
	logic accepted;

	assign accepted = wr.req && wrAck;
	// Two bytes in calibration, RESULT_BYTES otherwise
	assign lastByte = calibSession ? (wr.addr == OUTMEM_ADDRESS_WIDTH'(1))
		: (wr.addr == OUTMEM_ADDRESS_WIDTH'(RESULT_BYTES - 1));
	assign done = accepted && lastByte;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= writeIdle;
			wr <= '0;
			resultAddr <= '0;
			latCount <= '0;
			calibSession <= 1'b0;
		end else begin
			case (state)
				writeIdle: begin
					if (start) begin
						calibSession <= (mode == modeCalibrate);
						wr.addr <= '0;
						resultAddr <= '0;
						latCount <= '0;
						if (mode == modeCalibrate) begin
							wr.req <= 1'b1;
							wr.data <= response[15:8];	// High byte first
							state <= writeBusy;
						end else begin
							state <= writeSettle;
						end
					end
				end
				writeSettle: begin
					latCount <= latCount + 1'b1;
					if (latCount == LAT_WIDTH'(RESULT_READ_LATENCY)) begin
						wr.req <= 1'b1;
						wr.data <= resultData;
						state <= writeBusy;
					end
				end
				writeBusy: begin
					if (accepted) begin
						if (lastByte) begin
							wr.req <= 1'b0;
							state <= writeIdle;
						end else if (calibSession) begin
							wr.addr <= wr.addr + 1'b1;
							wr.data <= response[7:0];	// Straight on with the low byte
						end else begin
							wr.req <= 1'b0;
							wr.addr <= wr.addr + 1'b1;
							resultAddr <= resultAddr + 1'b1;	// Same index on both sides
							latCount <= '0;
							state <= writeSettle;
						end
					end
				end
				default: state <= writeIdle;
			endcase
		end
	end

	// Stalled write keeps its address and data
	assert property (@(posedge clk) disable iff (reset)
		wr.req && !wrAck |=> wr.req && $stable(wr.addr) && $stable(wr.data));

endmodule

//--- hw/sircHandler.sv
`timescale 1ns/10ps

module sircHandler import pufPkg::*; #(
	parameter int RESULT_BYTES = 16,
	parameter int CALIB_WAIT_CYCLES = 10,
	parameter int RESULT_READ_LATENCY = 2,
	parameter int RESULT_ADDRESS_WIDTH = 13
) (
	input logic clk,
	input logic reset,

	// Run register
	input logic userRunValue,
	output logic userRunClear,

	// Parameter register file, read only
	output logic register32CmdReq,
	output logic [7:0] register32Address,
	input logic register32CmdAck,
	input logic register32ReadDataValid,
	input logic [31:0] register32ReadData,

	// Input memory
	output logic inputMemoryReadReq,
	output logic [INMEM_ADDRESS_WIDTH-1:0] inputMemoryReadAdd,
	input logic inputMemoryReadAck,
	input logic inputMemoryReadDataValid,
	input logic [7:0] inputMemoryReadData,

	// Output memory
	output logic outputMemoryWriteReq,
	output logic [OUTMEM_ADDRESS_WIDTH-1:0] outputMemoryWriteAdd,
	output logic [7:0] outputMemoryWriteData,
	input logic outputMemoryWriteAck,

	// PUF evaluator and its result memory
	output evalCtrl_t pufCtrl,
	output pdlConfig_t pufConfig,
	output logic [31:0] pufChallenge,
	output logic [RESULT_ADDRESS_WIDTH-1:0] resultAddr,
	input logic pufTestDone,
	input rawResponse_t pufRawResponse,
	input logic [7:0] resultData
);

	logic paramStart, loadStart, evalStart, writeStart;	// Phase strobes out
	logic paramDone, loadDone, evalDone, writeDone;		// Phase strobes back
	sessionParams_t params;
	memRead_t inRead;
	memWrite_t outWrite;
	rawResponse_t response;

	////////////////////
	// Struct to flat bus
	////////////////////

	assign inputMemoryReadReq = inRead.req;
	assign inputMemoryReadAdd = inRead.addr;
	assign outputMemoryWriteReq = outWrite.req;
	assign outputMemoryWriteAdd = outWrite.addr;
	assign outputMemoryWriteData = outWrite.data;
	assign pufChallenge = params.challenge;	// Held until the next session

	sessionControl session (
		.clk, .reset, .userRunValue, .userRunClear,
		.paramStart, .loadStart, .evalStart, .writeStart,
		.paramDone, .loadDone, .evalDone, .writeDone
	);

	paramReader reader (
		.clk, .reset, .start(paramStart),
		.regCmdReq(register32CmdReq), .regAddress(register32Address),
		.regCmdAck(register32CmdAck), .regReadValid(register32ReadDataValid),
		.regReadData(register32ReadData), .params, .done(paramDone)
	);

	challengeLoader loader (
		.clk, .reset, .start(loadStart), .rdReq(inRead),
		.rdAck(inputMemoryReadAck), .rdValid(inputMemoryReadDataValid),
		.rdData(inputMemoryReadData), .configData(pufConfig), .done(loadDone)
	);

	evalSequencer #(.CALIB_WAIT_CYCLES(CALIB_WAIT_CYCLES)) sequencer (
		.clk, .reset, .start(evalStart), .mode(params.mode), .ctrl(pufCtrl),
		.testDone(pufTestDone), .rawIn(pufRawResponse), .response, .done(evalDone)
	);

	resultWriter #(
		.RESULT_BYTES(RESULT_BYTES),
		.RESULT_READ_LATENCY(RESULT_READ_LATENCY),
		.RESULT_ADDRESS_WIDTH(RESULT_ADDRESS_WIDTH)
	) writer (
		.clk, .reset, .start(writeStart), .mode(params.mode), .response,
		.resultAddr, .resultData, .wr(outWrite), .wrAck(outputMemoryWriteAck),
		.done(writeDone)
	);

endmodule

//--- bench/hostModel.sv
`timescale 1ns/10ps

module hostModel import pufPkg::*; #(
	parameter int RESULT_ADDRESS_WIDTH = 13
) (
	input logic clk,
	input logic reset,
	input logic randomAcks,		// Acks after 0 to 3 cycles when high, at once when low
	input logic userRunValue,	// Host sets the run bit, output memory is wiped
	input logic register32CmdReq,
	input logic [7:0] register32Address,
	output logic register32CmdAck,
	output logic register32ReadDataValid,
	output logic [31:0] register32ReadData,
	input logic inputMemoryReadReq,
	input logic [INMEM_ADDRESS_WIDTH-1:0] inputMemoryReadAdd,
	output logic inputMemoryReadAck,
	output logic inputMemoryReadDataValid,
	output logic [7:0] inputMemoryReadData,
	input logic outputMemoryWriteReq,
	input logic [OUTMEM_ADDRESS_WIDTH-1:0] outputMemoryWriteAdd,
	input logic [7:0] outputMemoryWriteData,
	output logic outputMemoryWriteAck,
	input evalCtrl_t pufCtrl,
	input pdlConfig_t pufConfig,
	input logic [RESULT_ADDRESS_WIDTH-1:0] resultAddr,
	output logic pufTestDone,
	output rawResponse_t pufRawResponse,
	output logic [7:0] resultData
);

	localparam int TEST_DONE_DELAY = 20;	// Evaluator run time in test mode

	logic [31:0] regFile [0:PARAM_WORDS-1];		// Filled by the tests
	logic [7:0] inMem [0:CONFIG_BYTES-1];
	logic [7:0] outMem [0:255];
	int writeCount;								// Writes since the last run bit
	int seed;
	int testCount;
	logic [1:0] regWait, memWait, outWait;		// Cycles the pending request has waited
	logic [1:0] regDelay, memDelay, outDelay;	// Ack delay drawn for it
	logic [1:0] regPipeValid;					// Two-cycle register read pipeline
	logic [31:0] regPipeData [0:1];
	logic [7:0] resultStage;

	assign register32CmdAck = register32CmdReq && (regWait >= regDelay);
	assign inputMemoryReadAck = inputMemoryReadReq && (memWait >= memDelay);
	assign outputMemoryWriteAck = outputMemoryWriteReq && (outWait >= outDelay);
	assign register32ReadDataValid = regPipeValid[1];
	assign register32ReadData = regPipeData[1];
	assign pufRawResponse = foldConfig(pufConfig);

	// XOR of the eight 16-bit slices of the configuration
	function automatic rawResponse_t foldConfig(pdlConfig_t cfg);
		logic [127:0] flat;
		rawResponse_t folded;
		flat = cfg;
		folded = '0;
		for (int i = 0; i < 8; i++)
			folded = folded ^ flat[16*i +: 16];
		return folded;
	endfunction

	function automatic logic [1:0] drawDelay(logic randomOn);
		logic [31:0] r;
		r = $random(seed);
		return randomOn ? r[1:0] : 2'd0;
	endfunction

	task automatic advanceAck(input logic accepted, input logic waiting, input logic randomOn,
		inout logic [1:0] waitCycles, inout logic [1:0] delay);
		if (accepted) begin
			waitCycles = 2'd0;
			delay = drawDelay(randomOn);	// Fresh delay for the next request
		end else if (waiting) begin
			waitCycles = waitCycles + 2'd1;
		end
	endtask

	initial begin : model
		logic resetSeen, runSeen, randomSeen, testStartSeen;
		logic regAcc, memAcc, outAcc, regReqSeen, memReqSeen, outReqSeen;
		logic [7:0] regAddr, outAddr, outData, resAddr;
		logic [3:0] memAddr;
		seed = 18;
		{regWait, memWait, outWait} = '0;
		{regDelay, memDelay, outDelay} = '0;
		regPipeValid = '0;
		regPipeData[0] = '0;
		regPipeData[1] = '0;
		inputMemoryReadDataValid = 1'b0;
		inputMemoryReadData = '0;
		pufTestDone = 1'b0;
		resultStage = '0;
		resultData = '0;
		testCount = 0;
		writeCount = 0;
		forever begin
			@(posedge clk);
			// Everything as the DUT saw it at this edge
			resetSeen = reset;
			runSeen = userRunValue;
			randomSeen = randomAcks;
			testStartSeen = pufCtrl.testStart;
			regReqSeen = register32CmdReq;
			memReqSeen = inputMemoryReadReq;
			outReqSeen = outputMemoryWriteReq;
			regAcc = register32CmdReq && register32CmdAck;
			memAcc = inputMemoryReadReq && inputMemoryReadAck;
			outAcc = outputMemoryWriteReq && outputMemoryWriteAck;
			regAddr = register32Address;
			memAddr = inputMemoryReadAdd[3:0];
			outAddr = outputMemoryWriteAdd[7:0];
			outData = outputMemoryWriteData;
			resAddr = resultAddr[7:0];
			#1;
			if (resetSeen) begin
				{regWait, memWait, outWait} = '0;
				{regDelay, memDelay, outDelay} = '0;
				regPipeValid = '0;
				inputMemoryReadDataValid = 1'b0;
				pufTestDone = 1'b0;
				testCount = 0;
			end else begin
				if (runSeen) begin
					for (int i = 0; i < 256; i++)
						outMem[i] = ~8'(i);		// Never equals a written result
					writeCount = 0;
				end
				advanceAck(regAcc, regReqSeen, randomSeen, regWait, regDelay);
				advanceAck(memAcc, memReqSeen, randomSeen, memWait, memDelay);
				advanceAck(outAcc, outReqSeen, randomSeen, outWait, outDelay);
				regPipeValid[1] = regPipeValid[0];
				regPipeData[1] = regPipeData[0];
				regPipeValid[0] = regAcc;
				regPipeData[0] = regFile[regAddr[0]];
				inputMemoryReadDataValid = memAcc;	// Byte back one cycle after the ack
				if (memAcc)
					inputMemoryReadData = inMem[memAddr];
				if (outAcc) begin
					outMem[outAddr] = outData;
					writeCount++;
				end
				if (testStartSeen) begin
					if (testCount < TEST_DONE_DELAY)
						testCount++;
				end else begin
					testCount = 0;
				end
				pufTestDone = (testCount >= TEST_DONE_DELAY);	// Level until testStart drops
			end
			resultData = resultStage;		// Result memory, two-stage read
			resultStage = resAddr ^ 8'hA5;
		end
	end

endmodule

//--- bench/sircHandlerTb.sv
`timescale 1ns/10ps

module sircHandlerTb import pufPkg::*; ();

	localparam int RESULT_BYTES = 16;
	localparam int CALIB_WAIT_CYCLES = 10;
	localparam int RESULT_READ_LATENCY = 2;
	localparam int RESULT_ADDRESS_WIDTH = 13;
	localparam int TEST_COUNT = 6;
	localparam int CYCLE_LIMIT = TEST_COUNT * 400;	// Back-pressure test runs three sessions

	logic clk = 1'b0;
	logic reset;
	logic randomAcks;
	logic userRunValue, userRunClear;
	logic register32CmdReq, register32CmdAck, register32ReadDataValid;
	logic [7:0] register32Address;
	logic [31:0] register32ReadData;
	logic inputMemoryReadReq, inputMemoryReadAck, inputMemoryReadDataValid;
	logic [INMEM_ADDRESS_WIDTH-1:0] inputMemoryReadAdd;
	logic [7:0] inputMemoryReadData;
	logic outputMemoryWriteReq, outputMemoryWriteAck;
	logic [OUTMEM_ADDRESS_WIDTH-1:0] outputMemoryWriteAdd;
	logic [7:0] outputMemoryWriteData;
	evalCtrl_t pufCtrl;
	pdlConfig_t pufConfig;
	logic [31:0] pufChallenge;
	logic [RESULT_ADDRESS_WIDTH-1:0] resultAddr;
	logic pufTestDone;
	rawResponse_t pufRawResponse;
	logic [7:0] resultData;

	string testName;
	int errors = 0;
	int errorsAtStart;
	int testsRun = 0;
	int testsFailed = 0;
	logic [7:0] cfgBytes [0:CONFIG_BYTES-1];	// Bytes of the current session

	// Monitor counters that only count up
	int cycles = 0;
	int triggerPulses = 0;
	int clearCycles = 0;
	int testStartFalls = 0;
	int earlyFalls = 0;
	logic lastTestStart = 1'b0;
	logic lastTestDone = 1'b0;

	always #4 clk = ~clk;

	sircHandler #(
		.RESULT_BYTES(RESULT_BYTES),
		.CALIB_WAIT_CYCLES(CALIB_WAIT_CYCLES),
		.RESULT_READ_LATENCY(RESULT_READ_LATENCY),
		.RESULT_ADDRESS_WIDTH(RESULT_ADDRESS_WIDTH)
	) DUT (.*);

	hostModel #(.RESULT_ADDRESS_WIDTH(RESULT_ADDRESS_WIDTH)) host (.*);

	////////////////////
	// Monitor and timeout
	////////////////////

	always @(posedge clk) begin
		cycles++;
		if (pufCtrl.trigger)
			triggerPulses++;
		if (userRunClear)
			clearCycles++;
		if (lastTestStart && !pufCtrl.testStart) begin
			testStartFalls++;
			if (!lastTestDone)
				earlyFalls++;	// Dropped without the evaluator being done
		end
		lastTestStart = pufCtrl.testStart;
		lastTestDone = pufTestDone;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	////////////////////
	// Compare tasks
	////////////////////

	task automatic checkByte(string what, logic [7:0] expected, logic [7:0] actual);
		if (actual !== expected) begin
			$display("mismatch %s %s: expected %02h, actual %02h", testName, what,
				expected, actual);
			errors++;
		end
	endtask

	task automatic checkWord(string what, logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected) begin
			$display("mismatch %s %s: expected %08h, actual %08h", testName, what,
				expected, actual);
			errors++;
		end
	endtask

	task automatic checkResponse(string what, rawResponse_t expected, rawResponse_t actual);
		if (actual !== expected) begin
			$display("mismatch %s %s: expected %04h, actual %04h", testName, what,
				expected, actual);
			errors++;
		end
	endtask

	task automatic checkConfig(string what, pdlConfig_t expected, pdlConfig_t actual);
		if (actual !== expected) begin
			$display("mismatch %s %s: expected %032h, actual %032h", testName, what,
				expected, actual);
			errors++;
		end
	endtask

	task automatic checkCtrl(string what, evalCtrl_t expected, evalCtrl_t actual);
		if (actual !== expected) begin
			$display("mismatch %s %s: expected %04b, actual %04b", testName, what,
				expected, actual);
			errors++;
		end
	endtask

	task automatic checkCount(string what, int expected, int actual);
		if (actual != expected) begin
			$display("mismatch %s %s: expected %0d, actual %0d", testName, what,
				expected, actual);
			errors++;
		end
	endtask

	task automatic reportFailure(string text);
		$display("%s: %s", testName, text);
		errors++;
	endtask

	////////////////////
	// Session helpers
	////////////////////

	task automatic nextCycle();
		@(posedge clk);
		#1;		// Inputs change away from the edge
	endtask

	// High byte collects the odd lanes, low byte the even ones
	function automatic rawResponse_t foldBytes();
		rawResponse_t folded;
		folded = '0;
		for (int k = 0; k < CONFIG_BYTES; k += 2) begin
			folded[7:0] = folded[7:0] ^ cfgBytes[k];
			folded[15:8] = folded[15:8] ^ cfgBytes[k + 1];
		end
		return folded;
	endfunction

	task automatic loadStimulus(logic [31:0] modeWord, logic [31:0] challenge, logic [7:0] salt);
		host.regFile[0] = modeWord;
		host.regFile[1] = challenge;
		for (int k = 0; k < CONFIG_BYTES; k++) begin
			cfgBytes[k] = 8'(k * 29) ^ salt;
			host.inMem[k] = cfgBytes[k];
		end
	endtask

	task automatic runSession();
		userRunValue = 1'b1;	// One-cycle run pulse
		nextCycle();
		userRunValue = 1'b0;
		while (!userRunClear)
			nextCycle();
		repeat (2) nextCycle();	// Monitor sees the clear pulse and the cycle after it
	endtask

	task automatic runAndCheck(logic [31:0] modeWord, logic [31:0] challenge, logic [7:0] salt);
		int triggersBefore, clearsBefore, fallsBefore, earlyBefore;
		logic [127:0] flat;
		evalCtrl_t ctrlExpected;
		loadStimulus(modeWord, challenge, salt);
		triggersBefore = triggerPulses;
		clearsBefore = clearCycles;
		fallsBefore = testStartFalls;
		earlyBefore = earlyFalls;
		runSession();
		for (int k = 0; k < CONFIG_BYTES; k++)
			flat[8*k +: 8] = cfgBytes[k];		// Byte k at bits 8k+7 .. 8k
		ctrlExpected = '0;
		ctrlExpected.calibrate = (modeWord == 32'd0);
		ctrlExpected.readTemp = (modeWord == 32'd1);
		checkConfig("pufConfig", pdlConfig_t'(flat), pufConfig);
		checkWord("pufChallenge", challenge, pufChallenge);
		checkCtrl("pufCtrl", ctrlExpected, pufCtrl);
		checkCount("userRunClear cycles", 1, clearCycles - clearsBefore);
		if (modeWord == 32'd0) begin
			checkResponse("output bytes 0 and 1", foldBytes(), {host.outMem[0], host.outMem[1]});
			checkCount("writes", 2, host.writeCount);
			checkCount("trigger pulses", 1, triggerPulses - triggersBefore);
		end else begin
			for (int a = 0; a < RESULT_BYTES; a++)
				checkByte($sformatf("output byte %0d", a), 8'(a) ^ 8'hA5, host.outMem[a]);
			checkCount("writes", RESULT_BYTES, host.writeCount);
			checkCount("trigger pulses", 0, triggerPulses - triggersBefore);
			checkCount("testStart falls", 1, testStartFalls - fallsBefore);
			if (earlyFalls != earlyBefore)
				reportFailure("testStart fell before pufTestDone was raised");
		end
	endtask

	task automatic startTest(string name);
		testName = name;
		errorsAtStart = errors;
	endtask

	task automatic endTest();
		testsRun++;
		if (errors == errorsAtStart) begin
			$display("test %s: ok", testName);
		end else begin
			testsFailed++;
			$display("test %s: %0d errors", testName, errors - errorsAtStart);
		end
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic testCalibration();
		startTest("calibration");
		runAndCheck(32'd0, 32'h1234_5678, 8'h11);
		endTest();
	endtask

	task automatic testConfigChallenge();
		startTest("configuration and challenge");
		runAndCheck(32'd2, 32'h9E37_79B9, 8'hC3);	// Mode 2 also decodes as test
		endTest();
	endtask

	task automatic testTestMode();
		startTest("test mode");
		runAndCheck(32'h100, 32'h0BAD_F00D, 8'h4E);
		endTest();
	endtask

	task automatic testTemperature();
		startTest("temperature");
		runAndCheck(32'd1, 32'h5555_AAAA, 8'h72);
		endTest();
	endtask

	task automatic testBackPressure();
		startTest("back-pressure");
		randomAcks = 1'b1;
		runAndCheck(32'h100, 32'h0BAD_F00D, 8'h4E);
		runAndCheck(32'd2, 32'h9E37_79B9, 8'hC3);
		// Calibration last, so calibrate is still set when the next test resets
		runAndCheck(32'd0, 32'h1234_5678, 8'h11);
		randomAcks = 1'b0;
		endTest();
	endtask

	task automatic testMidSessionReset();
		startTest("reset in mid-session");
		loadStimulus(32'h100, 32'h0F0F_3C3C, 8'h5A);
		userRunValue = 1'b1;
		nextCycle();
		userRunValue = 1'b0;
		while (inputMemoryReadAdd != INMEM_ADDRESS_WIDTH'(5))
			nextCycle();
		reset = 1'b1;
		nextCycle();	// DUT clears at this edge
		if ({register32CmdReq, inputMemoryReadReq, outputMemoryWriteReq, userRunClear} != 4'b0)
			reportFailure("a request or userRunClear stayed high in reset");
		if (register32Address != '0 || inputMemoryReadAdd != '0
			|| outputMemoryWriteAdd != '0 || resultAddr != '0)
			reportFailure("an address was not zero in reset");
		checkCtrl("pufCtrl in reset", '0, pufCtrl);
		repeat (3) nextCycle();
		reset = 1'b0;
		nextCycle();
		runAndCheck(32'd0, 32'h7654_3210, 8'h21);
		endTest();
	endtask

	initial begin
		reset = 1'b1;
		userRunValue = 1'b0;
		randomAcks = 1'b0;
		repeat (16) nextCycle();
		reset = 1'b0;
		nextCycle();
		testCalibration();
		testConfigChallenge();
		testTestMode();
		testTemperature();
		testBackPressure();
		testMidSessionReset();
		$display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- flist.f
hw/pufPkg.sv
hw/sessionControl.sv
hw/paramReader.sv
hw/challengeLoader.sv
hw/evalSequencer.sv
hw/resultWriter.sv
hw/sircHandler.sv
bench/hostModel.sv
bench/sircHandlerTb.sv

//--- Makefile
RTL = hw/pufPkg.sv hw/sessionControl.sv hw/paramReader.sv hw/challengeLoader.sv \
	hw/evalSequencer.sv hw/resultWriter.sv hw/sircHandler.sv

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -sv -f flist.f --top-module sircHandlerTb \
		-Mdir obj_dir -o simv
	@out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

lint:
	verilator --lint-only -sv $(RTL) --top-module sircHandler

clean:
	rm -rf obj_dir
